//--- source/video_pkg.sv
`default_nettype none

package video_pkg;

	// horizontal timing in pixels
	localparam int h_visible = 640;
	localparam int h_front = 16;
	localparam int h_sync = 96;
	localparam int h_back = 48;
	localparam int h_total = h_visible + h_front + h_sync + h_back;

	// vertical timing in lines
	localparam int v_visible = 480;
	localparam int v_front = 10;
	localparam int v_sync = 2;
	localparam int v_back = 33;
	localparam int v_total = v_visible + v_front + v_sync + v_back;

	// character cell
	localparam int glyph_w = 8;
	localparam int glyph_h = 16;
	localparam int glyph_col_bits = $clog2(glyph_w);
	localparam int glyph_row_bits = $clog2(glyph_h);

	localparam int text_cols = h_visible / glyph_w;
	localparam int text_rows = v_visible / glyph_h;
	localparam int text_cells = text_cols * text_rows;
	localparam int cell_addr_w = $clog2(text_cells);

	localparam int glyph_count = 128;
	localparam int font_depth = glyph_count * glyph_h;
	localparam int font_addr_w = $clog2(font_depth);

	localparam logic [7:0] fg_level = 8'hFF;
	localparam logic [7:0] bg_level = 8'h00;
	localparam logic [7:0] char_blank = 8'h20;

endpackage

`default_nettype wire

//--- source/keyboard_pkg.sv
`default_nettype none

package keyboard_pkg;

	// frame is start, 8 data bits lsb first, odd parity, stop
	localparam int ps2_data_bits = 8;
	localparam int ps2_cnt_w = $clog2(ps2_data_bits);
	localparam logic ps2_start_level = 1'b0;
	localparam logic ps2_stop_level = 1'b1;

	// set 2 prefixes and keys handled specially
	localparam logic [7:0] sc_break = 8'hF0;
	localparam logic [7:0] sc_extended = 8'hE0;
	localparam logic [7:0] sc_enter = 8'h5A;

	typedef enum logic [1:0] {
		idle,
		data,
		parity,
		stop
	} ps2_rx_state_e;

	typedef enum logic [1:0] {
		op_none,
		op_print,
		op_newline
	} key_op_e;

endpackage

`default_nettype wire

//--- source/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
	input wire clk,
	input wire arst_n,
	input wire ps2_clk,
	input wire ps2_data,
	output logic scan_valid,
	output logic [7:0] scan_code
);

	logic [2:0] clk_sync;
	logic [1:0] data_sync;
	logic ps2_fall;
	logic bit_in;
	logic [7:0] shift_reg;
	logic [keyboard_pkg::ps2_cnt_w-1:0] bit_cnt;
	logic parity_ok;
	keyboard_pkg::ps2_rx_state_e state;

	// two sync flops, the third one only for edge detection
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync <= '1;
			data_sync <= '1;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	assign ps2_fall = clk_sync[2] & ~clk_sync[1];
	assign bit_in = data_sync[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= keyboard_pkg::idle;
			bit_cnt <= '0;
			parity_ok <= 1'b0;
			scan_valid <= 1'b0;
		end else begin
			scan_valid <= 1'b0;
			if (ps2_fall) begin
				case (state)
					keyboard_pkg::idle: begin
						bit_cnt <= '0;
						if (bit_in == keyboard_pkg::ps2_start_level) begin
							state <= keyboard_pkg::data;
						end
					end
					keyboard_pkg::data: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == keyboard_pkg::ps2_cnt_w'(keyboard_pkg::ps2_data_bits - 1)) begin
							state <= keyboard_pkg::parity;
						end
					end
					keyboard_pkg::parity: begin
						// odd parity over data plus parity bit
						parity_ok <= ^{shift_reg, bit_in};
						state <= keyboard_pkg::stop;
					end
					default: begin
						scan_valid <= parity_ok && (bit_in == keyboard_pkg::ps2_stop_level);
						state <= keyboard_pkg::idle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ps2_fall && state == keyboard_pkg::data) begin
			shift_reg <= {bit_in, shift_reg[7:1]};
		end
	end

	assign scan_code = shift_reg;

endmodule

`default_nettype wire

//--- source/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
	input wire clk,
	input wire arst_n,
	input wire scan_valid,
	input wire [7:0] scan_code,
	output logic key_valid,
	output keyboard_pkg::key_op_e key_op,
	output logic [7:0] key_char
);

	logic [7:0] ascii;
	keyboard_pkg::key_op_e op;
	logic skip_next;
	logic is_prefix;

	assign is_prefix = (scan_code == keyboard_pkg::sc_break) ||
		(scan_code == keyboard_pkg::sc_extended);

	// set 2 make codes
	always_comb begin
		case (scan_code)
			8'h1C: ascii = "A";
			8'h32: ascii = "B";
			8'h21: ascii = "C";
			8'h23: ascii = "D";
			8'h24: ascii = "E";
			8'h2B: ascii = "F";
			8'h34: ascii = "G";
			8'h33: ascii = "H";
			8'h43: ascii = "I";
			8'h3B: ascii = "J";
			8'h42: ascii = "K";
			8'h4B: ascii = "L";
			8'h3A: ascii = "M";
			8'h31: ascii = "N";
			8'h44: ascii = "O";
			8'h4D: ascii = "P";
			8'h15: ascii = "Q";
			8'h2D: ascii = "R";
			8'h1B: ascii = "S";
			8'h2C: ascii = "T";
			8'h3C: ascii = "U";
			8'h2A: ascii = "V";
			8'h1D: ascii = "W";
			8'h22: ascii = "X";
			8'h35: ascii = "Y";
			8'h1A: ascii = "Z";
			8'h45: ascii = "0";
			8'h16: ascii = "1";
			8'h1E: ascii = "2";
			8'h26: ascii = "3";
			8'h25: ascii = "4";
			8'h2E: ascii = "5";
			8'h36: ascii = "6";
			8'h3D: ascii = "7";
			8'h3E: ascii = "8";
			8'h46: ascii = "9";
			8'h29: ascii = " ";
			default: ascii = 8'h00;
		endcase
	end

	always_comb begin
		if (scan_code == keyboard_pkg::sc_enter) begin
			op = keyboard_pkg::op_newline;
		end else if (ascii != 8'h00) begin
			op = keyboard_pkg::op_print;
		end else begin
			op = keyboard_pkg::op_none;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			skip_next <= 1'b0;
			key_valid <= 1'b0;
			key_op <= keyboard_pkg::op_none;
		end else begin
			key_valid <= 1'b0;
			if (scan_valid) begin
				// E0 F0 xx keeps skip set until xx
				if (is_prefix) begin
					skip_next <= 1'b1;
				end else if (skip_next) begin
					skip_next <= 1'b0;
				end else if (op != keyboard_pkg::op_none) begin
					key_valid <= 1'b1;
					key_op <= op;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (scan_valid) begin
			key_char <= ascii;
		end
	end

endmodule

`default_nettype wire

//--- source/text_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module text_buffer (
	input wire clk,
	input wire arst_n,
	input wire key_valid,
	input wire keyboard_pkg::key_op_e key_op,
	input wire [7:0] key_char,
	input wire [6:0] rd_col,
	input wire [4:0] rd_row,
	output logic [7:0] rd_char
);

	logic [7:0] cells [video_pkg::text_cells];

	logic clearing;
	logic [video_pkg::cell_addr_w-1:0] clear_addr;
	logic [6:0] cur_col;
	logic [4:0] cur_row;
	logic [4:0] next_row;
	logic [video_pkg::cell_addr_w-1:0] cur_addr;
	logic [video_pkg::cell_addr_w-1:0] rd_addr;
	logic wr_en;
	logic [video_pkg::cell_addr_w-1:0] wr_addr;
	logic [7:0] wr_data;

	assign cur_addr = video_pkg::cell_addr_w'(cur_row) * video_pkg::cell_addr_w'(video_pkg::text_cols) +
		video_pkg::cell_addr_w'(cur_col);
	assign rd_addr = video_pkg::cell_addr_w'(rd_row) * video_pkg::cell_addr_w'(video_pkg::text_cols) +
		video_pkg::cell_addr_w'(rd_col);

	assign next_row = (cur_row == 5'(video_pkg::text_rows - 1)) ? 5'd0 : cur_row + 5'd1;

	// sweep owns the write port until done
	always_comb begin
		if (clearing) begin
			wr_en = 1'b1;
			wr_addr = clear_addr;
			wr_data = video_pkg::char_blank;
		end else begin
			wr_en = key_valid && (key_op == keyboard_pkg::op_print);
			wr_addr = cur_addr;
			wr_data = key_char;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			cells[wr_addr] <= wr_data;
		end
	end

	// blanking positions fall past the last cell
	always_ff @(posedge clk) begin
		if (rd_addr < video_pkg::cell_addr_w'(video_pkg::text_cells)) begin
			rd_char <= cells[rd_addr];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clearing <= 1'b1;
			clear_addr <= '0;
			cur_col <= '0;
			cur_row <= '0;
		end else if (clearing) begin
			if (clear_addr == video_pkg::cell_addr_w'(video_pkg::text_cells - 1)) begin
				clearing <= 1'b0;
			end
			clear_addr <= clear_addr + 1'b1;
		end else if (key_valid) begin
			case (key_op)
				keyboard_pkg::op_print: begin
					if (cur_col == 7'(video_pkg::text_cols - 1)) begin
						cur_col <= '0;
						cur_row <= next_row;
					end else begin
						cur_col <= cur_col + 7'd1;
					end
				end
				keyboard_pkg::op_newline: begin
					cur_col <= '0;
					cur_row <= next_row;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
	input wire clk,
	input wire arst_n,
	output logic [9:0] h_count,
	output logic [9:0] v_count,
	output logic hsync_raw,
	output logic vsync_raw,
	output logic visible_raw
);

	logic [9:0] h_next;
	logic [9:0] v_next;
	logic h_wrap;

	assign h_wrap = (h_count == 10'(video_pkg::h_total - 1));
	assign h_next = h_wrap ? 10'd0 : h_count + 10'd1;

	always_comb begin
		v_next = v_count;
		if (h_wrap) begin
			v_next = (v_count == 10'(video_pkg::v_total - 1)) ? 10'd0 : v_count + 10'd1;
		end
	end

	// flags decoded from the next position so they line up with the counters
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// park on the last pixel of the frame, first visible pixel follows
			h_count <= 10'(video_pkg::h_total - 1);
			v_count <= 10'(video_pkg::v_total - 1);
			hsync_raw <= 1'b1;
			vsync_raw <= 1'b1;
			visible_raw <= 1'b0;
		end else begin
			h_count <= h_next;
			v_count <= v_next;
			hsync_raw <= !((h_next >= 10'(video_pkg::h_visible + video_pkg::h_front)) &&
				(h_next < 10'(video_pkg::h_visible + video_pkg::h_front + video_pkg::h_sync)));
			vsync_raw <= !((v_next >= 10'(video_pkg::v_visible + video_pkg::v_front)) &&
				(v_next < 10'(video_pkg::v_visible + video_pkg::v_front + video_pkg::v_sync)));
			visible_raw <= (h_next < 10'(video_pkg::h_visible)) &&
				(v_next < 10'(video_pkg::v_visible));
		end
	end

endmodule

`default_nettype wire

//--- source/glyph_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module glyph_renderer (
	input wire clk,
	input wire arst_n,
	input wire [9:0] h_count,
	input wire [9:0] v_count,
	input wire hsync_raw,
	input wire vsync_raw,
	input wire visible_raw,
	input wire [7:0] rd_char,
	input wire font_we,
	input wire [10:0] font_addr,
	input wire [7:0] font_wdata,
	output logic [6:0] rd_col,
	output logic [4:0] rd_row,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	logic [7:0] font_mem [video_pkg::font_depth];

	logic [video_pkg::glyph_row_bits-1:0] glyph_row_s1;
	logic [video_pkg::glyph_col_bits-1:0] pixel_col_s1;
	logic hsync_s1;
	logic vsync_s1;
	logic visible_s1;
	logic [7:0] font_byte;
	logic pixel_on;
	logic [7:0] level;

	always_ff @(posedge clk) begin
		if (font_we) begin
			font_mem[font_addr] <= font_wdata;
		end
	end

	// cell lookup, text_buffer answers next cycle
	assign rd_col = h_count[9:video_pkg::glyph_col_bits];
	assign rd_row = v_count[video_pkg::glyph_row_bits +: 5];

	always_ff @(posedge clk) begin
		glyph_row_s1 <= v_count[video_pkg::glyph_row_bits-1:0];
		pixel_col_s1 <= h_count[video_pkg::glyph_col_bits-1:0];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hsync_s1 <= 1'b1;
			vsync_s1 <= 1'b1;
			visible_s1 <= 1'b0;
		end else begin
			hsync_s1 <= hsync_raw;
			vsync_s1 <= vsync_raw;
			visible_s1 <= visible_raw;
		end
	end

	// glyph * 16 + row, msb is the leftmost pixel
	assign font_byte = font_mem[{rd_char[6:0], glyph_row_s1}];
	assign pixel_on = font_byte[~pixel_col_s1];
	assign level = pixel_on ? video_pkg::fg_level : video_pkg::bg_level;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			vga_hsync <= hsync_s1;
			vga_vsync <= vsync_s1;
			vga_blank_n <= visible_s1;
			vga_r <= visible_s1 ? level : 8'h00;
			vga_g <= visible_s1 ? level : 8'h00;
			vga_b <= visible_s1 ? level : 8'h00;
		end
	end

endmodule

`default_nettype wire

//--- source/vga_term.sv
`timescale 1ns/1ps
`default_nettype none

module vga_term (
	input wire clk,
	input wire arst_n,
	input wire ps2_clk,
	input wire ps2_data,
	input wire font_we,
	input wire [10:0] font_addr,
	input wire [7:0] font_wdata,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	logic scan_valid;
	logic [7:0] scan_code;
	logic key_valid;
	keyboard_pkg::key_op_e key_op;
	logic [7:0] key_char;
	logic [6:0] rd_col;
	logic [4:0] rd_row;
	logic [7:0] rd_char;
	logic [9:0] h_count;
	logic [9:0] v_count;
	logic hsync_raw;
	logic vsync_raw;
	logic visible_raw;

	// keyboard path
	ps2_receiver i_ps2_receiver (
		.clk(clk),
		.arst_n(arst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.scan_valid(scan_valid),
		.scan_code(scan_code)
	);

	key_decoder i_key_decoder (
		.clk(clk),
		.arst_n(arst_n),
		.scan_valid(scan_valid),
		.scan_code(scan_code),
		.key_valid(key_valid),
		.key_op(key_op),
		.key_char(key_char)
	);

	text_buffer i_text_buffer (
		.clk(clk),
		.arst_n(arst_n),
		.key_valid(key_valid),
		.key_op(key_op),
		.key_char(key_char),
		.rd_col(rd_col),
		.rd_row(rd_row),
		.rd_char(rd_char)
	);

	// video path
	vga_timing i_vga_timing (
		.clk(clk),
		.arst_n(arst_n),
		.h_count(h_count),
		.v_count(v_count),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.visible_raw(visible_raw)
	);

	glyph_renderer i_glyph_renderer (
		.clk(clk),
		.arst_n(arst_n),
		.h_count(h_count),
		.v_count(v_count),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.visible_raw(visible_raw),
		.rd_char(rd_char),
		.font_we(font_we),
		.font_addr(font_addr),
		.font_wdata(font_wdata),
		.rd_col(rd_col),
		.rd_row(rd_row),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic arst_n
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held for three rising edges
	initial begin
		arst_n <= 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- verification/vga_term_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vga_term_tb;

	localparam int sel_hsync = 0;
	localparam int sel_vsync = 1;
	localparam int sel_blank = 2;
	localparam int sel_rst = 3;
	localparam int frame_cycles = video_pkg::h_total * video_pkg::v_total;
	localparam int line_limit = 40 * video_pkg::h_total;

	logic clk;
	logic arst_n;
	logic ps2_clk;
	logic ps2_data;
	logic font_we;
	logic [10:0] font_addr;
	logic [7:0] font_wdata;
	logic vga_hsync;
	logic vga_vsync;
	logic vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	logic [7:0] model [video_pkg::text_cells];
	logic [7:0] font_copy [video_pkg::font_depth];
	logic [16:0] lfsr_state;
	int cur_col;
	int cur_row;
	int error_count;
	int timeout_count;

	tb_clock i_tb_clock (
		.clk(clk),
		.arst_n(arst_n)
	);

	vga_term i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.font_we(font_we),
		.font_addr(font_addr),
		.font_wdata(font_wdata),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic next_byte(output logic [7:0] b);
		int k;
		b = '0;
		for (k = 0; k < 8; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	function automatic logic sig_value(input int sel);
		case (sel)
			sel_hsync: return vga_hsync;
			sel_vsync: return vga_vsync;
			sel_blank: return vga_blank_n;
			default: return arst_n;
		endcase
	endfunction

	// set 2 make codes of the keys used here
	function automatic logic [7:0] scan_of(input logic [7:0] c);
		case (c)
			"A": return 8'h1C;
			"B": return 8'h32;
			"C": return 8'h21;
			"D": return 8'h23;
			"E": return 8'h24;
			"F": return 8'h2B;
			"H": return 8'h33;
			"L": return 8'h4B;
			"O": return 8'h44;
			"R": return 8'h2D;
			"W": return 8'h1D;
			"0": return 8'h45;
			"1": return 8'h16;
			"2": return 8'h1E;
			"3": return 8'h26;
			default: return 8'h29;
		endcase
	endfunction

	function automatic logic [23:0] expected_rgb(input int line, input int px);
		logic [7:0] ch;
		logic [7:0] glyph;
		logic [7:0] lvl;
		ch = model[(line / video_pkg::glyph_h) * video_pkg::text_cols + px / video_pkg::glyph_w];
		glyph = font_copy[{ch[6:0], 4'(line % video_pkg::glyph_h)}];
		lvl = glyph[7 - (px % video_pkg::glyph_w)] ? video_pkg::fg_level : video_pkg::bg_level;
		return {lvl, lvl, lvl};
	endfunction

	task automatic finish_run();
		$display("checks done with %0d errors and %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		error_count++;
		if (error_count <= 32) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic give_up(input string what);
		timeout_count++;
		$display("timed out while waiting for %s", what);
	endtask

	task automatic wait_for(input int sel, input logic level, input int limit, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				give_up(what);
			end
		end while (timeout_count == 0 && sig_value(sel) != level);
	endtask

	// counts cycles while the signal holds its level
	task automatic measure_run(input int sel, input logic level, input int limit, output int n);
		n = 0;
		while (timeout_count == 0 && sig_value(sel) == level) begin
			n++;
			@(negedge clk);
			if (n > limit) begin
				give_up("end of a sync or blank run");
			end
		end
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk);
	endtask

	// start, 8 bits lsb first, odd parity, stop
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		int i;
		bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			@(posedge clk);
			ps2_data <= bits[i];
			wait_clocks(8);
			ps2_clk <= 1'b0;
			wait_clocks(8);
			ps2_clk <= 1'b1;
		end
		@(posedge clk);
		ps2_data <= 1'b1;
		wait_clocks(24);
	endtask

	task automatic model_print(input logic [7:0] c);
		model[cur_row * video_pkg::text_cols + cur_col] = c;
		cur_col++;
		if (cur_col == video_pkg::text_cols) begin
			cur_col = 0;
			cur_row = (cur_row + 1) % video_pkg::text_rows;
		end
	endtask

	task automatic type_text(input string s);
		int i;
		for (i = 0; i < s.len(); i++) begin
			send_frame(scan_of(s[i]), 1'b0);
			model_print(s[i]);
		end
	endtask

	task automatic press_enter();
		send_frame(keyboard_pkg::sc_enter, 1'b0);
		cur_col = 0;
		cur_row = (cur_row + 1) % video_pkg::text_rows;
	endtask

	task automatic load_font();
		int a;
		logic [7:0] b;
		for (a = 0; a < video_pkg::font_depth; a++) begin
			next_byte(b);
			font_copy[a] = b;
			@(posedge clk);
			font_we <= 1'b1;
			font_addr <= 11'(a);
			font_wdata <= b;
		end
		@(posedge clk);
		font_we <= 1'b0;
	endtask

	task automatic check_reset();
		wait_for(sel_rst, 1'b1, 10, "reset release");
		if (timeout_count == 0) begin
			assert (vga_hsync && vga_vsync && !vga_blank_n && {vga_r, vga_g, vga_b} == 24'h0) else
				value_error("reset state", {5'd0, 3'b110, 24'h0},
					{5'd0, vga_hsync, vga_vsync, vga_blank_n, vga_r, vga_g, vga_b});
		end
	endtask

	task automatic check_sync();
		int low;
		int high;
		wait_for(sel_hsync, 1'b0, 2 * video_pkg::h_total, "hsync low");
		measure_run(sel_hsync, 1'b0, video_pkg::h_total, low);
		measure_run(sel_hsync, 1'b1, video_pkg::h_total, high);
		if (timeout_count == 0) begin
			assert (low == video_pkg::h_sync) else value_error("hsync pulse", video_pkg::h_sync, low);
			assert (low + high == video_pkg::h_total) else
				value_error("hsync period", video_pkg::h_total, low + high);
		end
		wait_for(sel_vsync, 1'b0, frame_cycles, "vsync low");
		measure_run(sel_vsync, 1'b0, frame_cycles, low);
		measure_run(sel_vsync, 1'b1, frame_cycles, high);
		if (timeout_count == 0) begin
			assert (low == video_pkg::v_sync * video_pkg::h_total) else
				value_error("vsync pulse cycles", video_pkg::v_sync * video_pkg::h_total, low);
			assert (low + high == frame_cycles) else
				value_error("frame cycles", frame_cycles, low + high);
		end
		wait_for(sel_blank, 1'b1, line_limit, "blank_n high");
		measure_run(sel_blank, 1'b1, video_pkg::h_total, high);
		if (timeout_count == 0) begin
			assert (high == video_pkg::h_visible) else
				value_error("visible run", video_pkg::h_visible, high);
		end
	endtask

	// lines counted from the end of vsync, pixels from the rise of blank_n
	task automatic check_frame(input string name);
		int line;
		int px;
		logic [23:0] exp;
		wait_for(sel_vsync, 1'b0, frame_cycles, "vsync low");
		wait_for(sel_vsync, 1'b1, frame_cycles, "vsync high");
		for (line = 0; line < video_pkg::v_visible && timeout_count == 0; line++) begin
			wait_for(sel_blank, 1'b1, line_limit, "start of a visible line");
			for (px = 0; px < video_pkg::h_visible && timeout_count == 0; px++) begin
				if (px != 0) begin
					@(negedge clk);
				end
				exp = expected_rgb(line, px);
				assert (vga_blank_n && {vga_r, vga_g, vga_b} == exp) else
					value_error($sformatf("%s line %0d px %0d", name, line, px), {7'd0, 1'b1, exp},
						{7'd0, vga_blank_n, vga_r, vga_g, vga_b});
			end
		end
	endtask

	initial begin
		string pattern;
		int i;
		ps2_clk <= 1'b1;
		ps2_data <= 1'b1;
		font_we <= 1'b0;
		font_addr <= '0;
		font_wdata <= '0;
		lfsr_state = 17'd76021;
		error_count = 0;
		timeout_count = 0;
		cur_col = 0;
		cur_row = 0;
		for (i = 0; i < video_pkg::text_cells; i++) begin
			model[i] = video_pkg::char_blank;
		end

		check_reset();
		load_font();
		check_sync();
		check_frame("cleared screen");

		type_text("HELLO WORLD");
		press_enter();
		type_text("ABCDEF 0123");
		check_frame("typed characters");

		// release of A, extended arrow make and break, F1, corrupted A
		send_frame(keyboard_pkg::sc_break, 1'b0);
		send_frame(8'h1C, 1'b0);
		send_frame(keyboard_pkg::sc_extended, 1'b0);
		send_frame(8'h75, 1'b0);
		send_frame(keyboard_pkg::sc_extended, 1'b0);
		send_frame(keyboard_pkg::sc_break, 1'b0);
		send_frame(8'h75, 1'b0);
		send_frame(8'h05, 1'b0);
		send_frame(8'h1C, 1'b1);
		check_frame("filtered keys");

		// 81 characters wrap onto the following row
		press_enter();
		pattern = "0123ABCDEFHLORW ";
		for (i = 0; i < video_pkg::text_cols + 1; i++) begin
			type_text(pattern.substr(i % pattern.len(), i % pattern.len()));
		end
		// a wrapped cursor sends this enter past the spilled character
		press_enter();
		type_text("W");
		check_frame("cursor wrap");

		finish_run();
	end

endmodule

`default_nettype wire

//--- vga_term.f
source/video_pkg.sv
source/keyboard_pkg.sv
source/ps2_receiver.sv
source/key_decoder.sv
source/text_buffer.sv
source/vga_timing.sv
source/glyph_renderer.sv
source/vga_term.sv
verification/tb_clock.sv
verification/vga_term_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it into a log and check for the pass line

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module vga_term_tb -f vga_term.f -o vga_term_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/vga_term_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx '\*\* PASS \*\*' "$log"; then
	exit 0
else
	echo "pass line not found in $log"
	exit 1
fi
